// ==== mem_sched_pkg.sv ====
package mem_sched_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int OP_W   = 2;

    typedef logic [ADDR_W-1:0] addr_t; // Word address.
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [OP_W-1:0]   op_t;

    // Request tags.
    localparam op_t OP_NONE  = 2'd0;
    localparam op_t OP_READ  = 2'd1;
    localparam op_t OP_WRITE = 2'd2;

    // One queued request, 66 bits.
    typedef struct packed {
        op_t   op;
        addr_t addr;
        data_t wdata;
    } req_t;

    typedef enum logic {
        ST_IDLE,
        ST_BUS
    } master_state_t;

endpackage

// ==== request_buffer.sv ====
`timescale 1ns/1ps

module request_buffer #(
    parameter int DEPTH = 64
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  push_ren,
    input  logic                  push_wen,
    input  mem_sched_pkg::addr_t  push_addr,
    input  mem_sched_pkg::data_t  push_wdata,
    input  logic                  pop,
    output mem_sched_pkg::req_t   head,
    output mem_sched_pkg::req_t   next,
    output logic                  head_valid,
    output logic                  next_valid,
    output logic                  full
);

    // The head stays in place while it is on the bus, so one slot more.
    localparam int SLOTS = DEPTH + 1;
    localparam int PTR_W = $clog2(SLOTS);
    localparam int CNT_W = $clog2(SLOTS + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(SLOTS - 1);

    mem_sched_pkg::req_t fifo [SLOTS];
    mem_sched_pkg::req_t entry;

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [PTR_W-1:0] rptr_nxt;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] res;
        if (ptr == LAST_PTR) begin
            res = '0;
        end else begin
            res = ptr + 1'b1;
        end
        return res;
    endfunction

    assign full       = (count == CNT_W'(SLOTS));
    assign head_valid = (count != '0);
    assign next_valid = (count > CNT_W'(1));

    assign push_ok = (push_ren || push_wen) && !full;
    assign pop_ok  = pop && head_valid;

    // Read wins over write.
    always_comb begin
        entry.addr  = push_addr;
        entry.wdata = push_wdata;
        if (push_ren) begin
            entry.op = mem_sched_pkg::OP_READ;
        end else if (push_wen) begin
            entry.op = mem_sched_pkg::OP_WRITE;
        end else begin
            entry.op = mem_sched_pkg::OP_NONE;
        end
    end

    assign rptr_nxt = wrap_inc(rptr);
    assign head     = fifo[rptr];
    assign next     = fifo[rptr_nxt]; // Lookahead entry.

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            fifo[wptr] <= entry;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push_ok) begin
                wptr <= wrap_inc(wptr);
            end
            if (pop_ok) begin
                rptr <= rptr_nxt;
            end
        end
    end

    // Occupancy, including the entry on the bus.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== wb_request_master.sv ====
`timescale 1ns/1ps

module wb_request_master (
    input  logic                  CLK,
    input  logic                  nRST,
    input  mem_sched_pkg::req_t   head,
    input  mem_sched_pkg::req_t   next,
    input  logic                  head_valid,
    input  logic                  next_valid,
    output logic                  pop,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output mem_sched_pkg::addr_t  wb_adr,
    output mem_sched_pkg::data_t  wb_dat_o,
    input  mem_sched_pkg::data_t  wb_dat_i,
    input  logic                  wb_ack,
    input  logic                  wb_err,
    output logic                  done,
    output logic                  done_err,
    output logic                  done_write,
    output mem_sched_pkg::addr_t  done_addr,
    output mem_sched_pkg::data_t  done_rdata
);

    mem_sched_pkg::master_state_t state;
    mem_sched_pkg::req_t          load_req;

    logic bus_end;
    logic load_en;

    // Single word classic cycle, so cyc and stb move together.
    assign wb_cyc = (state == mem_sched_pkg::ST_BUS);
    assign wb_stb = wb_cyc;

    assign bus_end = (state == mem_sched_pkg::ST_BUS) && (wb_ack || wb_err);
    assign pop     = bus_end && head_valid; // Head is the request on the bus.

    // Start from idle, or chain the lookahead entry with no gap.
    always_comb begin
        if (state == mem_sched_pkg::ST_IDLE) begin
            load_en  = head_valid;
            load_req = head;
        end else begin
            load_en  = bus_end && next_valid;
            load_req = next;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= mem_sched_pkg::ST_IDLE;
            wb_we <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= bus_end;
            if (load_en) begin
                wb_we <= (load_req.op == mem_sched_pkg::OP_WRITE);
            end
            case (state)
                mem_sched_pkg::ST_IDLE: begin
                    if (head_valid) begin
                        state <= mem_sched_pkg::ST_BUS;
                    end
                end
                mem_sched_pkg::ST_BUS: begin
                    if (bus_end && !next_valid) begin
                        state <= mem_sched_pkg::ST_IDLE;
                    end
                end
                default: state <= mem_sched_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (load_en) begin
            wb_adr   <= load_req.addr;
            wb_dat_o <= load_req.wdata;
        end
    end

    // Completion is captured from the bus before it is reloaded.
    always_ff @(posedge CLK) begin
        if (bus_end) begin
            done_addr  <= wb_adr; // Callback.
            done_rdata <= wb_dat_i;
            done_err   <= wb_err;
            done_write <= wb_we;
        end
    end

endmodule

// ==== mem_scheduler.sv ====
`timescale 1ns/1ps

module mem_scheduler #(
    parameter int DEPTH = 64
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_ren,
    input  logic                  req_wen,
    input  mem_sched_pkg::addr_t  req_addr,
    input  mem_sched_pkg::data_t  req_wdata,
    output logic                  full,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output mem_sched_pkg::addr_t  wb_adr,
    output mem_sched_pkg::data_t  wb_dat_o,
    input  mem_sched_pkg::data_t  wb_dat_i,
    input  logic                  wb_ack,
    input  logic                  wb_err,
    output logic                  done,
    output logic                  done_err,
    output logic                  done_write,
    output mem_sched_pkg::addr_t  done_addr,
    output mem_sched_pkg::data_t  done_rdata
);

    mem_sched_pkg::req_t head;
    mem_sched_pkg::req_t next;
    logic                head_valid;
    logic                next_valid;
    logic                pop;

    request_buffer #(
        .DEPTH(DEPTH)
    ) u_buffer (
        .CLK        (CLK),
        .nRST       (nRST),
        .push_ren   (req_ren),
        .push_wen   (req_wen),
        .push_addr  (req_addr),
        .push_wdata (req_wdata),
        .pop        (pop),
        .head       (head),
        .next       (next),
        .head_valid (head_valid),
        .next_valid (next_valid),
        .full       (full)
    );

    wb_request_master u_master (
        .CLK        (CLK),
        .nRST       (nRST),
        .head       (head),
        .next       (next),
        .head_valid (head_valid),
        .next_valid (next_valid),
        .pop        (pop),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .done       (done),
        .done_err   (done_err),
        .done_write (done_write),
        .done_addr  (done_addr),
        .done_rdata (done_rdata)
    );

endmodule

// ==== wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  mem_sched_pkg::addr_t  adr,
    input  mem_sched_pkg::data_t  dat_w,
    output mem_sched_pkg::data_t  dat_r,
    output logic                  ack,
    output logic                  err,
    input  logic [1:0]            waits,
    input  logic                  stall
);

    mem_sched_pkg::data_t mem [256];
    logic [1:0]           wcnt;
    logic                 hit;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) ^ 32'ha5a5_0000;
        end
    end

    assign hit   = cyc && stb && !stall && (wcnt >= waits);
    assign ack   = hit && !adr[7];
    assign err   = hit && adr[7]; // Upper half answers err.
    assign dat_r = mem[adr[7:0]];

    // Wait states seen so far in this cycle.
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wcnt <= 2'd0;
        end else if (hit || !stb) begin
            wcnt <= 2'd0;
        end else if (wcnt != 2'd3) begin
            wcnt <= wcnt + 2'd1;
        end
    end

    always @(posedge CLK) begin
        if (ack && we) begin
            mem[adr[7:0]] <= dat_w;
        end
    end

endmodule

// ==== mem_scheduler_sva.sv ====
`timescale 1ns/1ps

module mem_scheduler_sva (
    input logic                          CLK,
    input logic                          nRST,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_we,
    input logic                          wb_ack,
    input logic                          wb_err,
    input logic                          done,
    input mem_sched_pkg::addr_t          wb_adr,
    input mem_sched_pkg::master_state_t  state
);

    stb_in_cyc: assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // Request held until the slave answers.
    bus_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_stb && !wb_ack && !wb_err) |=> ($stable(wb_adr) && $stable(wb_we)))
        else $error("wb_adr or wb_we changed during a pending cycle");

    done_after_end: assert property (@(posedge CLK) disable iff (!nRST)
        done |-> $past(wb_stb && (wb_ack || wb_err)))
        else $error("done without a bus cycle ending");

    idle_no_cyc: assert property (@(posedge CLK) disable iff (!nRST)
        (state == mem_sched_pkg::ST_IDLE) |-> !wb_cyc)
        else $error("wb_cyc high while idle");

endmodule

bind wb_request_master mem_scheduler_sva u_sva (
    .CLK    (CLK),
    .nRST   (nRST),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we  (wb_we),
    .wb_ack (wb_ack),
    .wb_err (wb_err),
    .done   (done),
    .wb_adr (wb_adr),
    .state  (state)
);

// ==== tb_mem_scheduler.sv ====
`timescale 1ns/1ps

module tb_mem_scheduler;

    localparam int DEPTH = 8;

    logic CLK;
    logic nRST;
    logic req_ren;
    logic req_wen;
    logic full;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic wb_ack;
    logic wb_err;
    logic done;
    logic done_err;
    logic done_write;
    logic stall;
    logic [1:0] waits;
    mem_sched_pkg::addr_t req_addr;
    mem_sched_pkg::addr_t wb_adr;
    mem_sched_pkg::addr_t done_addr;
    mem_sched_pkg::addr_t chain_addr;
    mem_sched_pkg::data_t req_wdata;
    mem_sched_pkg::data_t wb_dat_o;
    mem_sched_pkg::data_t wb_dat_i;
    mem_sched_pkg::data_t done_rdata;
    mem_sched_pkg::data_t shadow [256];
    mem_sched_pkg::req_t  exp_q [$];
    logic [31:0] rng;
    logic        chain_due;
    logic        chain_we;
    int          err_cnt;
    int          tmo_cnt;
    int          acc_cnt;
    int          base;

    mem_scheduler #(.DEPTH(DEPTH)) UUT (
        .CLK(CLK), .nRST(nRST), .req_ren(req_ren), .req_wen(req_wen),
        .req_addr(req_addr), .req_wdata(req_wdata), .full(full),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .wb_err(wb_err),
        .done(done), .done_err(done_err), .done_write(done_write),
        .done_addr(done_addr), .done_rdata(done_rdata)
    );

    wb_mem_model u_mem (
        .CLK(CLK), .nRST(nRST), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_o), .dat_r(wb_dat_i), .ack(wb_ack), .err(wb_err),
        .waits(waits), .stall(stall)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Few addresses so reads hit earlier writes. Bit 7 set now and then.
    function automatic mem_sched_pkg::addr_t make_addr(input logic [31:0] r);
        mem_sched_pkg::addr_t a;
        a    = r & 32'h0f00_000f;
        a[7] = (r[6:4] == 3'd0);
        return a;
    endfunction

    task automatic check_addr(input string name, input mem_sched_pkg::addr_t got,
                              input mem_sched_pkg::addr_t exp_val);
        if (got !== exp_val) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp_val);
            err_cnt++;
        end
    endtask

    task automatic check_data(input string name, input mem_sched_pkg::data_t got,
                              input mem_sched_pkg::data_t exp_val);
        if (got !== exp_val) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp_val);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp_val);
            err_cnt++;
        end
    endtask

    task automatic drive_random(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge CLK);
            #10;
            rng       = xorshift32(rng);
            req_ren   = rng[0] & rng[2];
            req_wen   = rng[1] & rng[3]; // Both high means read.
            waits     = rng[9:8];
            rng       = xorshift32(rng);
            req_addr  = make_addr(rng);
            rng       = xorshift32(rng);
            req_wdata = rng;
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n       = 0;
        @(posedge CLK);
        #10;
        req_ren = 1'b0;
        req_wen = 1'b0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge CLK);
            #10;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d requests still pending after %0d cycles",
                     exp_q.size(), limit);
            tmo_cnt++;
        end
    endtask

    // Reference model. Completions first, then this edge's accepted strobe.
    always @(posedge CLK) begin : model
        mem_sched_pkg::req_t front;
        int idx;
        if (done) begin
            if (exp_q.size() == 0) begin
                $display("Completion at %0t ns with no pending request", $time);
                err_cnt++;
            end else begin
                front = exp_q.pop_front();
                idx   = int'(front.addr[7:0]);
                check_addr("done_addr", done_addr, front.addr);
                check_bit("done_write", done_write, front.op == mem_sched_pkg::OP_WRITE);
                check_bit("done_err", done_err, front.addr[7]);
                if (!front.addr[7]) begin
                    if (front.op == mem_sched_pkg::OP_WRITE) begin
                        shadow[idx] = front.wdata;
                    end else begin
                        check_data("done_rdata", done_rdata, shadow[idx]);
                    end
                end
                check_data("mem word", u_mem.mem[idx], shadow[idx]);
            end
        end
        if (chain_due) begin
            check_bit("wb_cyc", wb_cyc, 1'b1);
            check_bit("wb_stb", wb_stb, 1'b1);
            check_bit("wb_we", wb_we, chain_we);
            check_addr("wb_adr", wb_adr, chain_addr);
        end
        chain_due = 1'b0;
        if (wb_cyc && (wb_ack || wb_err) && exp_q.size() >= 2) begin
            chain_due  = 1'b1; // Next request goes out on this edge.
            chain_addr = exp_q[1].addr;
            chain_we   = (exp_q[1].op == mem_sched_pkg::OP_WRITE);
        end
        if (nRST && (req_ren || req_wen) && !full) begin
            front.op    = req_ren ? mem_sched_pkg::OP_READ : mem_sched_pkg::OP_WRITE;
            front.addr  = req_addr;
            front.wdata = req_wdata;
            exp_q.push_back(front);
            acc_cnt++;
        end
    end

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        req_ren   = 1'b0;
        req_wen   = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        waits     = 2'd0;
        stall     = 1'b0;
        rng       = 32'h3c25;
        chain_due = 1'b0;
        err_cnt   = 0;
        tmo_cnt   = 0;
        acc_cnt   = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem_sched_pkg::data_t'(i) ^ 32'ha5a5_0000;
        end
        repeat (3) @(posedge CLK);
        #10;
        nRST = 1'b1;
        drive_random(300);
        wait_drained(200);
        // Stalled slave. Queue fills, extra strobes are dropped.
        stall = 1'b1;
        base  = acc_cnt;
        for (int i = 0; i < DEPTH + 4; i++) begin
            @(posedge CLK);
            #10;
            check_bit("full", full, (acc_cnt - base) >= DEPTH + 1);
            rng       = xorshift32(rng);
            req_ren   = 1'b0;
            req_wen   = 1'b1;
            req_addr  = make_addr(rng);
            req_wdata = xorshift32(rng);
        end
        @(posedge CLK);
        #10;
        check_bit("full", full, 1'b1);
        req_wen = 1'b0;
        if (acc_cnt - base != DEPTH + 1) begin
            $display("Stalled slave accepted %0d requests instead of %0d",
                     acc_cnt - base, DEPTH + 1);
            err_cnt++;
        end
        waits = 2'd0; // Zero wait states for back-to-back cycles.
        stall = 1'b0;
        wait_drained(200);
        drive_random(200);
        wait_drained(200);
        waits = 2'd0;
        for (int i = 0; i < 16; i++) begin
            @(posedge CLK);
            #10;
            req_ren  = 1'b1;
            req_addr = mem_sched_pkg::addr_t'(i);
        end
        wait_drained(200);
        repeat (5) @(posedge CLK);
        $display("Errors: %0d value, %0d timeout", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== build.f ====
mem_sched_pkg.sv
request_buffer.sv
wb_request_master.sv
mem_scheduler.sv
wb_mem_model.sv
mem_scheduler_sva.sv
tb_mem_scheduler.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_mem_scheduler -o sim_mem_scheduler

./obj_dir/sim_mem_scheduler > sim.log 2>&1
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
